/* bench/intc_tb.sv */
`include "intc_settings.svh"

module intc_tb;

	localparam int plan_cycles = 520;
	localparam int timeout_cycles = 4 * plan_cycles;

	logic clk;
	logic reset;
	logic cs;
	logic [3:0] adr;
	logic oe;
	logic we;
	logic [7:0] data_i;
	logic [7:0] data_o;
	logic [6:0] lines;
	logic ack;
	logic dtack;
	logic [2:0] ipl;

	integer seed = 32'h00cf6511;

	// model of the controller state, stepped on the same edges as the DUT
	logic [7:0] m_vec [7];
	logic [2:0] m_lvl [7];
	logic [6:0] m_en;
	logic [6:0] m_pend;
	logic [6:0] m_lines_q;
	logic m_ack_q;
	logic [2:0] m_ipl;
	logic [2:0] m_active;
	logic [7:0] m_data;
	logic m_dtack;
	logic checking = 1'b0;
	int checks = 0;
	int errors = 0;
	int cycles = 0;

	intc_top dut0
	(
		.clk (clk),
		.reset (reset),
		.cs (cs),
		.adr (adr),
		.oe (oe),
		.we (we),
		.data_i (data_i),
		.data_o (data_o),
		.int1 (lines[0]),
		.int2 (lines[1]),
		.int3 (lines[2]),
		.int4 (lines[3]),
		.int5 (lines[4]),
		.int6 (lines[5]),
		.int7 (lines[6]),
		.ack (ack),
		.dtack (dtack),
		.ipl (ipl)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [2:0] top_pending(input logic [6:0] mask);
		logic [2:0] idx;
		idx = 3'd0;
		for (int i = 0; i < 7; i++)
		begin
			if (mask[i])
			begin
				idx = 3'(i);
			end
		end
		return idx;
	endfunction

	function automatic logic [2:0] expected_ipl(input logic [6:0] mask);
		return ~m_lvl[top_pending(mask)];
	endfunction

	// adr 7 is the enable set and adr 15 reads as zero
	function automatic logic [7:0] read_value(input logic [3:0] a);
		if (a == `INTC_ENABLE_ADR)
		begin
			return {1'b0, m_en};
		end
		else if (a[2:0] == 3'b111)
		begin
			return 8'h00;
		end
		else if (!a[3])
		begin
			return m_vec[a[2:0]];
		end
		return {5'b0, m_lvl[a[2:0]]};
	endfunction

	task automatic check_value(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("** Error at time %0t: %s expected %h actual %h",
				$time, name, expected, actual);
		end
	endtask

	always @(posedge clk)
	begin
		logic [6:0] rise;
		logic [6:0] fall;
		rise = lines & ~m_lines_q;
		fall = ~lines & m_lines_q;
		if (reset)
		begin
			for (int i = 0; i < 7; i++)
			begin
				m_vec[i] <= 8'(`INTC_VECTOR_BASE + i);
				m_lvl[i] <= 3'(i + 1);
			end
			m_en <= 7'h7f;
			m_pend <= 7'h00;
			m_lines_q <= 7'h00;
			m_ack_q <= 1'b0;
			m_ipl <= 3'b111;
			m_active <= 3'd0;
			m_data <= 8'h00;
			m_dtack <= 1'b1;
		end
		else
		begin
			if (cs && we)
			begin
				if (adr == `INTC_ENABLE_ADR)
				begin
					m_en <= data_i[6:0];
				end
				else if (adr[2:0] != 3'b111 && adr[3])
				begin
					m_lvl[adr[2:0]] <= data_i[2:0];
				end
				else if (adr[2:0] != 3'b111)
				begin
					m_vec[adr[2:0]] <= data_i;
				end
			end
			m_pend <= (m_pend & ~fall) | (rise & m_en);
			if (m_ack_q && !ack)
			begin
				m_ipl <= 3'b111;
			end
			else if (m_ipl == 3'b111 && m_pend != 7'h00)
			begin
				m_active <= top_pending(m_pend);
				m_ipl <= expected_ipl(m_pend);
			end
			if (ack)
			begin
				if (!m_ack_q)
				begin
					m_data <= m_vec[m_active];
				end
				m_dtack <= (m_ipl == 3'b111);
			end
			else if (cs && oe && !we)
			begin
				m_data <= read_value(adr);
				m_dtack <= 1'b0;
			end
			else
			begin
				m_data <= 8'h00;
				m_dtack <= 1'b1;
			end
			m_lines_q <= lines;
			m_ack_q <= ack;
		end
	end

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk)
	begin
		if (checking)
		begin
			check_value("ipl", 8'(m_ipl), 8'(ipl));
			check_value("data_o", m_data, data_o);
			check_value("dtack", 8'(m_dtack), 8'(dtack));
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= timeout_cycles)
		begin
			$display("the run timed out after %0d cycles without finishing", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic wait_dtack(input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (dtack !== 1'b0 && n < 4)
		begin
			@(negedge clk);
			n++;
		end
		if (dtack !== 1'b0)
		begin
			errors++;
			$display("dtack never went low for the %s at time %0t", what, $time);
		end
	endtask

	task automatic wait_ipl();
		int n;
		n = 0;
		@(negedge clk);
		while (ipl === 3'b111 && n < 6)
		begin
			@(negedge clk);
			n++;
		end
		if (ipl === 3'b111)
		begin
			errors++;
			$display("ipl was never raised for a pending line at time %0t", $time);
		end
	endtask

	task automatic bus_access(input logic write, input logic [3:0] a, input logic [7:0] d);
		@(posedge clk);
		cs <= 1'b1;
		we <= write;
		oe <= !write;
		adr <= a;
		data_i <= d;
		@(posedge clk);
		cs <= 1'b0;
		we <= 1'b0;
		oe <= 1'b0;
		if (!write)
		begin
			wait_dtack("register read");
		end
	endtask

	task automatic ack_cycle(input int hold);
		@(posedge clk);
		ack <= 1'b1;
		wait_dtack("acknowledge");
		check_value("ack vector", m_vec[m_active], data_o);
		repeat (hold) @(posedge clk);
		ack <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	initial
	begin
		logic [31:0] r;
		reset = 1'b1;
		cs = 1'b0;
		adr = 4'h0;
		oe = 1'b0;
		we = 1'b0;
		data_i = 8'h00;
		lines = 7'h00;
		ack = 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		checking <= 1'b1;

		for (int a = 0; a < 16; a++)
		begin
			bus_access(1'b0, 4'(a), 8'h00);
		end

		repeat (40)
		begin
			r = $random(seed);
			bus_access(1'b1, r[3:0], r[15:8]);
		end
		for (int a = 0; a < 16; a++)
		begin
			bus_access(1'b0, 4'(a), 8'h00);
		end

		// back to the reset levels and all sources enabled
		for (int i = 0; i < 7; i++)
		begin
			bus_access(1'b1, 4'(i + 8), 8'(i + 1));
		end
		bus_access(1'b1, `INTC_ENABLE_ADR, 8'h7f);

		@(posedge clk);
		lines <= 7'b0101010;
		wait_ipl();
		check_value("ipl", 8'(expected_ipl(7'b0101010)), 8'(ipl));

		// the same source comes back while its line stays high
		ack_cycle(2);
		wait_ipl();
		@(posedge clk);
		lines <= 7'b0001010;
		ack_cycle(1);
		wait_ipl();
		check_value("ipl", 8'(expected_ipl(7'b0001010)), 8'(ipl));
		@(posedge clk);
		lines <= 7'h00;
		ack_cycle(1);

		bus_access(1'b1, `INTC_ENABLE_ADR, 8'h0f);
		@(posedge clk);
		lines <= 7'b1110000;
		repeat (6) @(posedge clk);
		lines <= 7'h00;
		@(negedge clk);
		check_value("ipl", 8'h07, 8'(ipl));
		bus_access(1'b1, `INTC_ENABLE_ADR, 8'h7f);
		@(posedge clk);
		lines <= 7'b0000101;
		wait_ipl();
		@(posedge clk);
		lines <= 7'b0000001;
		ack_cycle(1);
		wait_ipl();
		check_value("ipl", 8'(expected_ipl(7'b0000001)), 8'(ipl));
		@(posedge clk);
		lines <= 7'h00;
		ack_cycle(1);

		repeat (200)
		begin
			@(posedge clk);
			r = $random(seed);
			lines <= r[6:0];
			cs <= r[7];
			we <= r[8] & r[9];
			oe <= r[10];
			adr <= r[15:12];
			data_i <= r[23:16];
			ack <= r[24] & r[25];
		end
		@(posedge clk);
		cs <= 1'b0;
		we <= 1'b0;
		oe <= 1'b0;
		ack <= 1'b0;
		lines <= 7'h00;
		repeat (4) @(posedge clk);
		@(negedge clk);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
		begin
			$display("Result: PASSED");
		end
		else
		begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* common/intc_pkg.sv */
`include "intc_settings.svh"

package intc_pkg;

	// which register a bus access lands on
	typedef enum logic [1:0]
	{
		TGT_NONE,
		TGT_VECTOR,
		TGT_LEVEL,
		TGT_ENABLE
	} reg_target_t;

	// index of one interrupt source, 0 to 6
	typedef logic [2:0] src_idx_t;

	// level 0 is a source that never reaches ipl
	typedef logic [2:0] level_t;

	typedef logic [`INTC_DATA_W-1:0] vector_t;

	// one bit per source, used for the enable and pending sets
	typedef logic [`INTC_NUM_SOURCES-1:0] src_mask_t;

endpackage

/* common/intc_reg_if.sv */
`include "intc_settings.svh"

interface intc_reg_if
	import intc_pkg::*;
();
	// read and write strobes last a single cycle
	logic rd;
	logic wr;
	reg_target_t target;
	src_idx_t index;
	logic [`INTC_DATA_W-1:0] wdata;

	modport decode
	(
		output rd,
		output wr,
		output target,
		output index,
		output wdata
	);

	modport file
	(
		input rd,
		input wr,
		input target,
		input index,
		input wdata
	);

	// the response only needs to know that a read happened and where it went
	modport response
	(
		input rd,
		input target
	);

endinterface

/* common/intc_settings.svh */
`ifndef INTC_SETTINGS_SVH
`define INTC_SETTINGS_SVH

// number of interrupt lines, int1 is source 0 and int7 is source 6
`define INTC_NUM_SOURCES 7

// width of the bus data path and of a vector register
`define INTC_DATA_W 8

// the only register on the low address half that is not a vector
`define INTC_ENABLE_ADR 4'h7

// vector i comes out of reset as this base plus i
`define INTC_VECTOR_BASE 25

`endif

/* compile.f */
+incdir+common
common/intc_pkg.sv
common/intc_reg_if.sv
intc/intc_reg_decode.sv
intc/intc_reg_file.sv
intc/intc_priority.sv
intc/intc_bus_response.sv
intc/intc_top.sv
bench/intc_tb.sv

/* intc/intc_bus_response.sv */
`include "intc_settings.svh"

module intc_bus_response
	import intc_pkg::*;
(
	input  logic clk,
	input  logic reset,
	intc_reg_if.response bus,
	input  logic ack,
	input  logic ipl_active,
	input  vector_t rd_data,
	input  vector_t ack_vector,
	output vector_t data_o,
	output logic dtack
);

	logic ack_q;
	logic ack_rise;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack_q <= 1'b0;
		end
		else
		begin
			ack_q <= ack;
		end
	end

	assign ack_rise = ack && !ack_q;

	// dtack is active low, an acknowledge outranks a register read
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			data_o <= '0;
			dtack <= 1'b1;
		end
		else if (ack)
		begin
			// the vector is captured once and held while ack stays high
			if (ack_rise)
			begin
				data_o <= ack_vector;
			end
			dtack <= !ipl_active;
		end
		else if (bus.rd)
		begin
			// unmapped addresses still get dtack but read back as zero
			data_o <= (bus.target == TGT_NONE) ? '0 : rd_data;
			dtack <= 1'b0;
		end
		else
		begin
			data_o <= '0;
			dtack <= 1'b1;
		end
	end

endmodule

/* intc/intc_priority.sv */
`include "intc_settings.svh"

module intc_priority
	import intc_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  src_mask_t irq,
	input  logic ack,
	input  src_mask_t enable,
	input  level_t [`INTC_NUM_SOURCES-1:0] levels,
	output logic [2:0] ipl,
	output src_idx_t active_src,
	output logic ipl_active
);

	localparam logic [2:0] ipl_idle = 3'b111;

	src_mask_t irq_q;
	src_mask_t rise;
	src_mask_t fall;
	src_mask_t pending;
	logic ack_q;
	logic ack_fall;
	logic any_pending;
	src_idx_t top_src;

	// previous samples of the lines and of ack for edge detection
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			irq_q <= '0;
			ack_q <= 1'b0;
		end
		else
		begin
			irq_q <= irq;
			ack_q <= ack;
		end
	end

	assign rise = irq & ~irq_q;
	assign fall = ~irq & irq_q;
	assign ack_fall = ack_q && !ack;

	// a disabled source ignores its rising edge but still clears when the line drops
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pending <= '0;
		end
		else
		begin
			pending <= (pending & ~fall) | (rise & enable);
		end
	end

	assign any_pending = |pending;

	// the highest index wins, so the loop lets later sources override earlier ones
	always_comb
	begin
		top_src = '0;
		for (int i = 0; i < `INTC_NUM_SOURCES; i++)
		begin
			if (pending[i])
			begin
				top_src = src_idx_t'(i);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ipl <= ipl_idle;
			active_src <= '0;
		end
		else if (ack_fall)
		begin
			// the cpu has taken the vector, ipl may rise again one edge later
			ipl <= ipl_idle;
		end
		else if (ipl == ipl_idle && any_pending)
		begin
			active_src <= top_src;
			ipl <= ~levels[top_src];
		end
	end

	// a source with level 0 inverts to idle and is therefore never presented
	assign ipl_active = (ipl != ipl_idle);

endmodule

/* intc/intc_reg_decode.sv */
`include "intc_settings.svh"

module intc_reg_decode
	import intc_pkg::*;
(
	input  logic cs,
	input  logic [3:0] adr,
	input  logic oe,
	input  logic we,
	input  logic [`INTC_DATA_W-1:0] data_i,
	intc_reg_if.decode bus
);

	logic adr_in_table;

	// addresses 7 and 15 sit outside both register tables
	assign adr_in_table = (adr[2:0] != 3'b111);

	// a write takes precedence when oe and we are both set
	assign bus.wr = cs && we;
	assign bus.rd = cs && oe && !we;

	assign bus.index = src_idx_t'(adr[2:0]);
	assign bus.wdata = data_i;

	always_comb
	begin
		if (adr == `INTC_ENABLE_ADR)
		begin
			bus.target = TGT_ENABLE;
		end
		else if (!adr[3] && adr_in_table)
		begin
			bus.target = TGT_VECTOR;
		end
		else if (adr[3] && adr_in_table)
		begin
			bus.target = TGT_LEVEL;
		end
		else
		begin
			// adr 15 lands here and is read back as zero
			bus.target = TGT_NONE;
		end
	end

endmodule

/* intc/intc_reg_file.sv */
`include "intc_settings.svh"

module intc_reg_file
	import intc_pkg::*;
(
	input  logic clk,
	input  logic reset,
	intc_reg_if.file bus,
	input  src_idx_t active_src,
	output src_mask_t enable,
	output level_t [`INTC_NUM_SOURCES-1:0] levels,
	output vector_t rd_data,
	output vector_t ack_vector
);

	vector_t vectors [`INTC_NUM_SOURCES];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// vectors start at the base and level i+1 belongs to source i
			for (int i = 0; i < `INTC_NUM_SOURCES; i++)
			begin
				vectors[i] <= vector_t'(`INTC_VECTOR_BASE + i);
				levels[i] <= level_t'(i + 1);
			end
			enable <= '1;
		end
		else if (bus.wr)
		begin
			case (bus.target)
				TGT_VECTOR:
				begin
					vectors[bus.index] <= bus.wdata;
				end
				TGT_LEVEL:
				begin
					// a level only has three bits, the rest of the byte is dropped
					levels[bus.index] <= bus.wdata[2:0];
				end
				TGT_ENABLE:
				begin
					enable <= bus.wdata[`INTC_NUM_SOURCES-1:0];
				end
				default:
				begin
				end
			endcase
		end
	end

	always_comb
	begin
		rd_data = '0;
		if (bus.rd)
		begin
			case (bus.target)
				TGT_VECTOR:
				begin
					rd_data = vectors[bus.index];
				end
				TGT_LEVEL:
				begin
					rd_data = vector_t'(levels[bus.index]);
				end
				TGT_ENABLE:
				begin
					rd_data = vector_t'(enable);
				end
				default:
				begin
					rd_data = '0;
				end
			endcase
		end
	end

	// the vector handed out during an acknowledge follows the source on ipl
	assign ack_vector = vectors[active_src];

endmodule

/* intc/intc_top.sv */
`include "intc_settings.svh"

module intc_top
	import intc_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic cs,
	input  logic [3:0] adr,
	input  logic oe,
	input  logic we,
	input  logic [`INTC_DATA_W-1:0] data_i,
	output logic [`INTC_DATA_W-1:0] data_o,
	input  logic int1,
	input  logic int2,
	input  logic int3,
	input  logic int4,
	input  logic int5,
	input  logic int6,
	input  logic int7,
	input  logic ack,
	output logic dtack,
	output logic [2:0] ipl
);

	src_mask_t irq;
	src_mask_t enable;
	level_t [`INTC_NUM_SOURCES-1:0] levels;
	src_idx_t active_src;
	logic ipl_active;
	vector_t rd_data;
	vector_t ack_vector;

	// int7 is the top bit and so the highest priority
	assign irq = {int7, int6, int5, int4, int3, int2, int1};

	intc_reg_if reg_bus ();

	intc_reg_decode u_decode
	(
		.cs (cs),
		.adr (adr),
		.oe (oe),
		.we (we),
		.data_i (data_i),
		.bus (reg_bus.decode)
	);

	intc_reg_file u_reg_file
	(
		.clk (clk),
		.reset (reset),
		.bus (reg_bus.file),
		.active_src (active_src),
		.enable (enable),
		.levels (levels),
		.rd_data (rd_data),
		.ack_vector (ack_vector)
	);

	intc_priority u_priority
	(
		.clk (clk),
		.reset (reset),
		.irq (irq),
		.ack (ack),
		.enable (enable),
		.levels (levels),
		.ipl (ipl),
		.active_src (active_src),
		.ipl_active (ipl_active)
	);

	intc_bus_response u_response
	(
		.clk (clk),
		.reset (reset),
		.bus (reg_bus.response),
		.ack (ack),
		.ipl_active (ipl_active),
		.rd_data (rd_data),
		.ack_vector (ack_vector),
		.data_o (data_o),
		.dtack (dtack)
	);

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module intc_tb -o intc_sim

out=$(./obj_dir/intc_sim)
echo "$out"

if echo "$out" | grep -q "^Result: PASSED$"; then
	exit 0
else
	exit 1
fi
